// File: flist.f
hdl/sparcPkg.sv
hdl/instrBuffer.sv
hdl/instrDecoder.sv
hdl/regFile.sv
hdl/operandForward.sv
hdl/intAlu.sv
hdl/sparcIntCore.sv
verif/sparcIntCoreTb.sv

// File: hdl/instrBuffer.sv
`timescale 1ns/1ps

module instrBuffer #(
    parameter int Depth = 4
) (
    input  logic           Clk,
    input  logic           rstN,
    input  logic           push,
    input  sparcPkg::wordT pushData,
    input  logic           pop,
    output sparcPkg::wordT headData,
    output logic           notEmpty,
    output logic           credit
);

    localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW = $clog2(Depth + 1);

    sparcPkg::wordT  mem [Depth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;
    logic            doPop;

    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] p);
        return (p == PtrW'(Depth - 1)) ? '0 : p + 1'b1;   // Wrap at Depth
    endfunction

    assign notEmpty = (count != '0);
    assign doPop    = pop && notEmpty;
    assign headData = mem[rdPtr];

    always_ff @(posedge Clk)
    begin
        if (push)
        begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            wrPtr  <= '0;
            rdPtr  <= '0;
            count  <= '0;
            credit <= 1'b0;
        end
        else
        begin
            credit <= doPop;    // One credit per entry leaving
            if (push)
            begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop)
            begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({push, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Source must never send beyond its credits
    assert property (@(posedge Clk) disable iff (!rstN) push |-> (count != CntW'(Depth)));

endmodule

// File: hdl/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  sparcPkg::wordT    instr,
    output sparcPkg::aluOpT   aluOp,
    output sparcPkg::regAddrT rd,
    output sparcPkg::regAddrT rs1,
    output sparcPkg::regAddrT rs2,
    output logic              useImm,
    output sparcPkg::wordT    imm,
    output logic              writesRd,
    output logic              modifyCc,
    output logic              readsRs1,
    output logic              readsRs2
);

    localparam int XLen = sparcPkg::XLen;

    logic [1:0]      opField;
    logic [5:0]      op3;
    logic [2:0]      op2;
    logic            arithKnown;    // Low op3 nibble maps to an ALU op
    logic            shiftGroup;
    logic            isArith;
    logic            isSethi;
    sparcPkg::aluOpT arithOp;

    assign opField = instr[sparcPkg::OpHi:sparcPkg::OpLo];
    assign op3     = instr[sparcPkg::Op3Hi:sparcPkg::Op3Lo];
    assign op2     = instr[sparcPkg::Op2Hi:sparcPkg::Op2Lo];

    always_comb
    begin
        arithKnown = 1'b1;
        case (op3[3:0])
            4'h0: arithOp = sparcPkg::OpAdd;
            4'h8: arithOp = sparcPkg::OpAddx;
            4'h4: arithOp = sparcPkg::OpSub;
            4'hc: arithOp = sparcPkg::OpSubx;
            4'h1: arithOp = sparcPkg::OpAnd;
            4'h2: arithOp = sparcPkg::OpOr;
            4'h3: arithOp = sparcPkg::OpXor;
            4'h5: arithOp = instr[sparcPkg::Op3ShiftBit] ? sparcPkg::OpSll : sparcPkg::OpAndn;
            4'h6: arithOp = instr[sparcPkg::Op3ShiftBit] ? sparcPkg::OpSrl : sparcPkg::OpOrn;
            4'h7: arithOp = instr[sparcPkg::Op3ShiftBit] ? sparcPkg::OpSra : sparcPkg::OpXnor;
            default:
            begin
                arithOp    = sparcPkg::OpAdd;
                arithKnown = 1'b0;
            end
        endcase
    end

    // Shifts have no cc form and no other op3 with bit 24 set is handled
    assign shiftGroup = (op3[3:2] == 2'b01) && (op3[1:0] != 2'b00);
    assign isArith    = (opField == sparcPkg::FmtArith) && arithKnown &&
                        (!instr[sparcPkg::Op3ShiftBit] ||
                         (shiftGroup && !instr[sparcPkg::Op3CcBit]));
    assign isSethi    = (opField == sparcPkg::FmtSethi) && (op2 == sparcPkg::Op2Sethi);

    assign aluOp  = isSethi ? sparcPkg::OpPassB : arithOp;
    assign rd     = instr[sparcPkg::RdHi:sparcPkg::RdLo];
    assign rs1    = instr[sparcPkg::Rs1Hi:sparcPkg::Rs1Lo];
    assign rs2    = instr[sparcPkg::Rs2Hi:sparcPkg::Rs2Lo];
    assign useImm = isSethi || instr[sparcPkg::IBit];

    // imm22 goes to the top and simm13 is sign-extended
    assign imm = isSethi ?
                 {instr[sparcPkg::Imm22Hi:sparcPkg::Imm22Lo], {(XLen - 22){1'b0}}} :
                 {{(XLen - 13){instr[sparcPkg::Simm13Hi]}},
                  instr[sparcPkg::Simm13Hi:sparcPkg::Simm13Lo]};

    assign writesRd = isArith || isSethi;   // Low means bubble
    assign modifyCc = isArith && instr[sparcPkg::Op3CcBit];
    assign readsRs1 = isArith;
    assign readsRs2 = isArith && !instr[sparcPkg::IBit];

endmodule

// File: hdl/intAlu.sv
`timescale 1ns/1ps

module intAlu (
    input  sparcPkg::aluOpT op,
    input  sparcPkg::wordT  a,
    input  sparcPkg::wordT  b,
    input  logic            carryIn,
    output sparcPkg::wordT  result,
    output sparcPkg::iccT   icc
);

    localparam int XLen = sparcPkg::XLen;

    logic [XLen:0] wide;        // Sum or difference with carry out
    logic          carryTerm;
    logic          vFlag;
    logic          cFlag;

    assign carryTerm = carryIn && ((op == sparcPkg::OpAddx) || (op == sparcPkg::OpSubx));

    always_comb
    begin
        wide   = '0;
        result = '0;
        vFlag  = 1'b0;
        cFlag  = 1'b0;
        case (op)
            sparcPkg::OpAdd, sparcPkg::OpAddx:
            begin
                wide   = {1'b0, a} + {1'b0, b} + {{XLen{1'b0}}, carryTerm};
                result = wide[XLen-1:0];
                cFlag  = wide[XLen];
                vFlag  = (a[XLen-1] == b[XLen-1]) && (result[XLen-1] != a[XLen-1]);
            end
            sparcPkg::OpSub, sparcPkg::OpSubx:
            begin
                wide   = {1'b0, a} - {1'b0, b} - {{XLen{1'b0}}, carryTerm};
                result = wide[XLen-1:0];
                cFlag  = wide[XLen];    // Borrow
                vFlag  = (a[XLen-1] != b[XLen-1]) && (result[XLen-1] != a[XLen-1]);
            end
            sparcPkg::OpAnd:   result = a & b;
            sparcPkg::OpOr:    result = a | b;
            sparcPkg::OpXor:   result = a ^ b;
            sparcPkg::OpXnor:  result = ~(a ^ b);
            sparcPkg::OpAndn:  result = a & ~b;
            sparcPkg::OpOrn:   result = a | ~b;
            sparcPkg::OpSll:   result = a << b[4:0];
            sparcPkg::OpSrl:   result = a >> b[4:0];
            sparcPkg::OpSra:   result = sparcPkg::wordT'($signed(a) >>> b[4:0]);
            sparcPkg::OpPassB: result = b;
            default:           result = '0;
        endcase
    end

    // Logic and shift ops leave V and C clear
    assign icc = {result[XLen-1], (result == '0), vFlag, cFlag};

endmodule

// File: hdl/operandForward.sv
`timescale 1ns/1ps

module operandForward (
    input  sparcPkg::regAddrT rs1,
    input  sparcPkg::regAddrT rs2,
    input  sparcPkg::regAddrT eRd,
    input  sparcPkg::regAddrT wRd,
    input  logic              eWrites,
    input  logic              wWrites,
    output sparcPkg::fwdSelT  selA,
    output sparcPkg::fwdSelT  selB
);

    // The youngest producer wins so E beats W and W beats the register file
    function automatic sparcPkg::fwdSelT pickSource(
        input sparcPkg::regAddrT src,
        input sparcPkg::regAddrT eDst,
        input sparcPkg::regAddrT wDst,
        input logic              eWr,
        input logic              wWr
    );
        sparcPkg::fwdSelT sel;
        sel = sparcPkg::FwdRf;
        if (src != '0)          // r0 is never forwarded
        begin
            if (eWr && (eDst == src))
            begin
                sel = sparcPkg::FwdE;
            end
            else if (wWr && (wDst == src))
            begin
                sel = sparcPkg::FwdW;
            end
        end
        return sel;
    endfunction

    assign selA = pickSource(rs1, eRd, wRd, eWrites, wWrites);
    assign selB = pickSource(rs2, eRd, wRd, eWrites, wWrites);

endmodule

// File: hdl/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic              Clk,
    input  logic              rstN,
    input  sparcPkg::regAddrT raddrA,
    input  sparcPkg::regAddrT raddrB,
    input  sparcPkg::regAddrT waddr,
    input  sparcPkg::wordT    wdata,
    input  logic              wen,
    output sparcPkg::wordT    rdataA,
    output sparcPkg::wordT    rdataB
);

    sparcPkg::wordT regs [1:31];    // No storage for r0

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wen && (waddr != '0))
        begin
            regs[waddr] <= wdata;
        end
    end

    // r0 always reads as zero
    assign rdataA = (raddrA == '0) ? '0 : regs[raddrA];
    assign rdataB = (raddrB == '0) ? '0 : regs[raddrB];

endmodule

// File: hdl/sparcIntCore.sv
`timescale 1ns/1ps

module sparcIntCore #(
    parameter int InDepth    = 4,
    parameter int ResCredits = 2
) (
    input  logic              Clk,
    input  logic              rstN,
    input  logic              instrValid,
    input  sparcPkg::wordT    instr,
    input  logic              resCredit,
    output logic              instrCredit,
    output logic              resValid,
    output sparcPkg::regAddrT resRd,
    output sparcPkg::wordT    resData,
    output sparcPkg::iccT     resIcc
);

    localparam int CntW = $clog2(ResCredits + 1);

    sparcPkg::wordT    headData;
    logic              notEmpty;
    logic              pop;
    logic              advance;
    logic [CntW-1:0]   credCnt;

    logic              dValid;
    sparcPkg::wordT    dInstr;
    sparcPkg::aluOpT   dOp;
    sparcPkg::regAddrT dRd;
    sparcPkg::regAddrT dRs1;
    sparcPkg::regAddrT dRs2;
    logic              dUseImm;
    sparcPkg::wordT    dImm;
    logic              dWrites;
    logic              dModCc;
    logic              dReadsA;
    logic              dReadsB;
    sparcPkg::regAddrT srcA;
    sparcPkg::regAddrT srcB;
    sparcPkg::wordT    rfA;
    sparcPkg::wordT    rfB;
    sparcPkg::fwdSelT  selA;
    sparcPkg::fwdSelT  selB;
    sparcPkg::wordT    opA;
    sparcPkg::wordT    opB;

    logic              eValid;
    sparcPkg::aluOpT   eOp;
    sparcPkg::wordT    eA;
    sparcPkg::wordT    eB;
    sparcPkg::regAddrT eRd;
    logic              eModCc;
    sparcPkg::wordT    aluResult;
    sparcPkg::iccT     aluIcc;

    logic              wValid;
    sparcPkg::regAddrT wRd;
    sparcPkg::wordT    wData;
    sparcPkg::iccT     iccReg;

    function automatic sparcPkg::wordT pickOperand(
        input sparcPkg::fwdSelT sel,
        input sparcPkg::wordT   rfVal,
        input sparcPkg::wordT   eVal,
        input sparcPkg::wordT   wVal
    );
        case (sel)
            sparcPkg::FwdE: return eVal;
            sparcPkg::FwdW: return wVal;
            default:        return rfVal;
        endcase
    endfunction

    // Whole pipeline holds while W waits for a result credit
    assign advance  = !(wValid && (credCnt == '0));
    assign pop      = advance && notEmpty;
    assign resValid = wValid && (credCnt != '0);

    instrBuffer #(.Depth(InDepth)) i_instrBuffer (
        .Clk      (Clk),
        .rstN     (rstN),
        .push     (instrValid),
        .pushData (instr),
        .pop      (pop),
        .headData (headData),
        .notEmpty (notEmpty),
        .credit   (instrCredit)
    );

    instrDecoder i_instrDecoder (
        .instr    (dInstr),
        .aluOp    (dOp),
        .rd       (dRd),
        .rs1      (dRs1),
        .rs2      (dRs2),
        .useImm   (dUseImm),
        .imm      (dImm),
        .writesRd (dWrites),
        .modifyCc (dModCc),
        .readsRs1 (dReadsA),
        .readsRs2 (dReadsB)
    );

    // Unused source fields read r0 so they never match a forward
    assign srcA = dReadsA ? dRs1 : '0;
    assign srcB = dReadsB ? dRs2 : '0;

    regFile i_regFile (
        .Clk    (Clk),
        .rstN   (rstN),
        .raddrA (srcA),
        .raddrB (srcB),
        .waddr  (wRd),
        .wdata  (wData),
        .wen    (resValid),     // Written as the result leaves
        .rdataA (rfA),
        .rdataB (rfB)
    );

    operandForward i_operandForward (
        .rs1     (srcA),
        .rs2     (srcB),
        .eRd     (eRd),
        .wRd     (wRd),
        .eWrites (eValid),
        .wWrites (wValid),
        .selA    (selA),
        .selB    (selB)
    );

    assign opA = pickOperand(selA, rfA, aluResult, wData);
    assign opB = dUseImm ? dImm : pickOperand(selB, rfB, aluResult, wData);

    intAlu i_intAlu (
        .op      (eOp),
        .a       (eA),
        .b       (eB),
        .carryIn (iccReg[0]),
        .result  (aluResult),
        .icc     (aluIcc)
    );

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            dValid <= 1'b0;
            eValid <= 1'b0;
            wValid <= 1'b0;
        end
        else if (advance)
        begin
            dValid <= notEmpty;
            eValid <= dValid && dWrites;    // Unsupported words drop here
            wValid <= eValid;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (advance)
        begin
            dInstr <= headData;
            eOp    <= dOp;
            eA     <= opA;
            eB     <= opB;
            eRd    <= dRd;
            eModCc <= dModCc;
            wRd    <= eRd;
            wData  <= aluResult;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            iccReg <= '0;
        end
        else if (advance && eValid && eModCc)
        begin
            iccReg <= aluIcc;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            credCnt <= CntW'(ResCredits);
        end
        else if (resCredit && !resValid)
        begin
            credCnt <= credCnt + 1'b1;
        end
        else if (!resCredit && resValid)
        begin
            credCnt <= credCnt - 1'b1;
        end
    end

    assign resRd   = wRd;
    assign resData = wData;
    assign resIcc  = iccReg;    // Holds the flags after the W instruction

    // Sink returns no more credits than it was given
    assert property (@(posedge Clk) disable iff (!rstN) credCnt <= CntW'(ResCredits));

endmodule

// File: hdl/sparcPkg.sv
package sparcPkg;

    localparam int XLen = 32;

    typedef logic [XLen-1:0] wordT;
    typedef logic [4:0]      regAddrT;
    typedef logic [3:0]      iccT;      // N Z V C
    typedef logic [3:0]      aluOpT;
    typedef logic [1:0]      fwdSelT;

    // ALU operation codes
    localparam aluOpT OpAdd   = 4'd0;
    localparam aluOpT OpAddx  = 4'd1;
    localparam aluOpT OpSub   = 4'd2;
    localparam aluOpT OpSubx  = 4'd3;
    localparam aluOpT OpAnd   = 4'd4;
    localparam aluOpT OpOr    = 4'd5;
    localparam aluOpT OpXor   = 4'd6;
    localparam aluOpT OpXnor  = 4'd7;
    localparam aluOpT OpAndn  = 4'd8;
    localparam aluOpT OpOrn   = 4'd9;
    localparam aluOpT OpSll   = 4'd10;
    localparam aluOpT OpSrl   = 4'd11;
    localparam aluOpT OpSra   = 4'd12;
    localparam aluOpT OpPassB = 4'd14;  // SETHI result

    localparam logic [1:0] FmtSethi = 2'd0;
    localparam logic [1:0] FmtArith = 2'd2;
    localparam logic [2:0] Op2Sethi = 3'd4;

    // Instruction field positions
    localparam int OpHi        = 31;
    localparam int OpLo        = 30;
    localparam int RdHi        = 29;
    localparam int RdLo        = 25;
    localparam int Op3Hi       = 24;
    localparam int Op3Lo       = 19;
    localparam int Op2Hi       = 24;
    localparam int Op2Lo       = 22;
    localparam int Op3ShiftBit = 24;    // Shifts instead of andn/orn/xnor
    localparam int Op3CcBit    = 23;
    localparam int Rs1Hi       = 18;
    localparam int Rs1Lo       = 14;
    localparam int IBit        = 13;
    localparam int Simm13Hi    = 12;
    localparam int Simm13Lo    = 0;
    localparam int Imm22Hi     = 21;
    localparam int Imm22Lo     = 0;
    localparam int Rs2Hi       = 4;
    localparam int Rs2Lo       = 0;

    // Operand source selects
    localparam fwdSelT FwdRf = 2'd0;
    localparam fwdSelT FwdE  = 2'd1;
    localparam fwdSelT FwdW  = 2'd2;

endpackage

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f flist.f --top-module sparcIntCoreTb --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
    echo "Pass message found in $LOG"
    exit 0
fi

echo "Pass message not found in $LOG"
exit 1

// File: verif/sparcIntCoreTb.sv
`timescale 1ns/1ps

module sparcIntCoreTb;

    localparam int InDepth       = 4;
    localparam int ResCredits    = 2;
    localparam int NumInstr      = 300;
    localparam int TimeoutCycles = 40 * NumInstr;

    // Supported op3 codes in plain and cc forms
    localparam logic [5:0] Op3List [23] = '{
        6'h00, 6'h10, 6'h08, 6'h18, 6'h04, 6'h14, 6'h0c, 6'h1c,
        6'h01, 6'h11, 6'h05, 6'h15, 6'h02, 6'h12, 6'h06, 6'h16,
        6'h03, 6'h13, 6'h07, 6'h17, 6'h25, 6'h26, 6'h27
    };

    logic              Clk = 1'b0;
    logic              rstN;
    logic              instrValid;
    sparcPkg::wordT    instr;
    logic              resCredit;
    logic              instrCredit;
    logic              resValid;
    sparcPkg::regAddrT resRd;
    sparcPkg::wordT    resData;
    sparcPkg::iccT     resIcc;

    int seed            = 33;
    int cycleCount      = 0;
    int srcCredits      = InDepth;  // Source side view
    int sentCount       = 0;
    int creditsReturned = 0;        // Result credits given back by the sink
    int pushes          = 0;        // Words seen entering the core
    int creditsBack     = 0;
    int resultsSeen     = 0;

    sparcPkg::wordT modelRegs [32] = '{default: '0};
    sparcPkg::iccT  modelIcc       = '0;
    logic [40:0]    expQ [$];       // {rd, data, icc}

    sparcIntCore #(
        .InDepth    (InDepth),
        .ResCredits (ResCredits)
    ) i_sparcIntCore (
        .Clk         (Clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .resCredit   (resCredit),
        .instrCredit (instrCredit),
        .resValid    (resValid),
        .resRd       (resRd),
        .resData     (resData),
        .resIcc      (resIcc)
    );

    always #5 Clk = ~Clk;

    task automatic abortRun();
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic compareValues(input logic [31:0] actual, input logic [31:0] expected,
                                 input string what);
        if (actual !== expected)
        begin
            $display("FAIL %0t %s: got %h, expected %h", $time, what, actual, expected);
            abortRun();
        end
    endtask

    function automatic sparcPkg::regAddrT pickReg();
        logic [31:0] d;
        d = $random(seed);
        return (d[7:5] != 3'd0) ? {2'b00, d[2:0]} : d[4:0];    // Mostly r0-r7
    endfunction

    function automatic sparcPkg::wordT makeInstr();
        logic [31:0]       d;
        logic [31:0]       e;
        sparcPkg::wordT    w;
        sparcPkg::regAddrT rd;
        sparcPkg::regAddrT rs1;
        sparcPkg::regAddrT rs2;
        logic [4:0]        idx;
        d   = $random(seed);
        e   = $random(seed);
        rd  = pickReg();
        rs1 = pickReg();
        rs2 = pickReg();
        idx = 5'(d[15:8] % 8'd23);
        if (d[4:0] < 5'd2)
        begin
            w     = e;
            w[30] = 1'b1;   // op 1 or 3 is never executed
        end
        else if (d[4:0] < 5'd6)
        begin
            w = {2'b00, rd, 3'b100, e[21:0]};  // SETHI
        end
        else if (d[20])
        begin
            w = {2'b10, rd, Op3List[idx], rs1, 1'b1, e[12:0]};
        end
        else
        begin
            w = {2'b10, rd, Op3List[idx], rs1, 1'b0, 8'h00, rs2};
        end
        return w;
    endfunction

    // Executes one word on the model state and returns 0 for a bubble
    function automatic logic predictResult(
        input  sparcPkg::wordT    word,
        output sparcPkg::regAddrT rd,
        output sparcPkg::wordT    data,
        output sparcPkg::iccT     icc
    );
        sparcPkg::wordT a;
        sparcPkg::wordT b;
        sparcPkg::wordT r;
        logic [5:0]     op3;
        logic           cin;
        logic           known;
        logic           cc;
        logic           v;
        logic           c;
        op3   = word[24:19];
        rd    = word[29:25];
        a     = modelRegs[word[18:14]];
        b     = word[13] ? {{19{word[12]}}, word[12:0]} : modelRegs[word[4:0]];
        cin   = op3[3] && modelIcc[0];  // Only the x forms take the carry
        known = 1'b1;
        cc    = 1'b0;
        v     = 1'b0;
        c     = 1'b0;
        r     = '0;
        if ((word[31:30] == 2'b00) && (word[24:22] == 3'b100))
        begin
            r = {word[21:0], 10'b0};
        end
        else if (word[31:30] == 2'b10)
        begin
            cc = op3[4];
            case (op3)
                6'h00, 6'h10, 6'h08, 6'h18:
                begin
                    r = a + b + {31'b0, cin};
                    v = (a[31] & b[31] & ~r[31]) | (~a[31] & ~b[31] & r[31]);
                    c = (a[31] & b[31]) | (~r[31] & (a[31] | b[31]));
                end
                6'h04, 6'h14, 6'h0c, 6'h1c:
                begin
                    r = a - b - {31'b0, cin};
                    v = (a[31] & ~b[31] & ~r[31]) | (~a[31] & b[31] & r[31]);
                    c = (~a[31] & b[31]) | (r[31] & (~a[31] | b[31]));  // Borrow
                end
                6'h01, 6'h11: r = a & b;
                6'h05, 6'h15: r = a & ~b;
                6'h02, 6'h12: r = a | b;
                6'h06, 6'h16: r = a | ~b;
                6'h03, 6'h13: r = a ^ b;
                6'h07, 6'h17: r = a ^ ~b;
                6'h25:        r = a << b[4:0];
                6'h26:        r = a >> b[4:0];
                6'h27:        r = 32'($signed(a) >>> b[4:0]);
                default:      known = 1'b0;
            endcase
        end
        else
        begin
            known = 1'b0;
        end
        if (known)
        begin
            if (cc)
            begin
                modelIcc = {r[31], (r == 32'd0), v, c};
            end
            if (rd != 5'd0)
            begin
                modelRegs[rd] = r;
            end
        end
        data = r;
        icc  = modelIcc;
        return known;
    endfunction

    task automatic driveSource();
        logic [31:0] d;
        d          = $random(seed);
        instrValid = 1'b0;
        if (instrCredit)
        begin
            srcCredits++;
        end
        if ((sentCount < NumInstr) && (srcCredits > 0) && (d[2:0] != 3'd0))
        begin
            instr      = makeInstr();
            instrValid = 1'b1;
            srcCredits--;
            sentCount++;
        end
    endtask

    task automatic driveSink();
        logic [31:0] d;
        d         = $random(seed);
        resCredit = 1'b0;
        // Every third window of 64 cycles the sink holds its credits back
        if (((resultsSeen - creditsReturned) > 0) && (((cycleCount / 64) % 3) != 1) &&
            (d[1:0] != 2'b00))
        begin
            resCredit = 1'b1;
            creditsReturned++;
        end
    endtask

    always @(posedge Clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount > TimeoutCycles)
        begin
            $display("Timeout after %0d cycles, %0d of %0d words sent, %0d results pending",
                     cycleCount, sentCount, NumInstr, expQ.size());
            abortRun();
        end
    end

    // Compares each result and models the words entering the core
    always @(negedge Clk)
    begin
        logic [40:0]       expected;
        sparcPkg::regAddrT pRd;
        sparcPkg::wordT    pData;
        sparcPkg::iccT     pIcc;
        int                heldCredits;
        if (rstN)
        begin
            if (resValid)
            begin
                heldCredits = ResCredits - resultsSeen + creditsReturned;
                if (resCredit)
                begin
                    heldCredits--;  // Counted by the core only at the next edge
                end
                if (heldCredits <= 0)
                begin
                    $display("Result for r%0d was sent while the core held no credit", resRd);
                    abortRun();
                end
                if (expQ.size() == 0)
                begin
                    $display("Result for r%0d appeared with no instruction outstanding", resRd);
                    abortRun();
                end
                else
                begin
                    expected = expQ.pop_front();
                    compareValues(32'(resRd), 32'(expected[40:36]),
                                  $sformatf("result %0d rd", resultsSeen));
                    compareValues(resData, expected[35:4],
                                  $sformatf("result %0d data", resultsSeen));
                    compareValues(32'(resIcc), 32'(expected[3:0]),
                                  $sformatf("result %0d icc", resultsSeen));
                    resultsSeen++;
                end
            end
            if (instrCredit)
            begin
                creditsBack++;
                if (creditsBack > pushes)
                begin
                    $display("The core returned more instruction credits than words it took");
                    abortRun();
                end
            end
            if (instrValid)
            begin
                if ((pushes - creditsBack) >= InDepth)
                begin
                    $display("An instruction was sent while the source held no credit");
                    abortRun();
                end
                pushes++;
                if (predictResult(instr, pRd, pData, pIcc))
                begin
                    expQ.push_back({pRd, pData, pIcc});
                end
            end
        end
    end

    initial
    begin
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        resCredit  = 1'b0;
        repeat (5) @(posedge Clk);
        #1;
        rstN = 1'b1;
        while (!((pushes == NumInstr) && (expQ.size() == 0)))
        begin
            @(posedge Clk);
            #1;
            driveSource();
            driveSink();
        end
        repeat (20)     // Quiet tail to catch stray results
        begin
            @(posedge Clk);
            #1;
            driveSource();
            driveSink();
        end
        if (srcCredits == InDepth)
        begin
            $display("SIMULATION PASSED");
            $finish;
        end
        else
        begin
            $display("Run ended with %0d results checked and %0d of %0d source credits back",
                     resultsSeen, srcCredits, InDepth);
            abortRun();
        end
    end

endmodule
